/* build.f */
logic/bexkat_pkg.sv
logic/bexkat_regfile.sv
logic/bexkat_alu.sv
logic/bexkat_control.sv
logic/bexkat_core.sv
verification/tb_bexkat_mem.sv
verification/tb_bexkat_core.sv

/* Bender.yml */
package:
  name: bexkat_core

sources:
  - logic/bexkat_pkg.sv
  - logic/bexkat_regfile.sv
  - logic/bexkat_alu.sv
  - logic/bexkat_control.sv
  - logic/bexkat_core.sv
  - target: test
    files:
      - verification/tb_bexkat_mem.sv
      - verification/tb_bexkat_core.sv

/* verification/tb_bexkat_core.sv */
`timescale 1ns/10ps

module tb_bexkat_core;

  import bexkat_pkg::*;

  localparam int wait_max      = 3;
  localparam int max_instr_cyc = 5 + 2 * (wait_max + 1); // two accesses with waits
  localparam int reset_cycles  = 5;
  localparam int idle_cycles   = 30;

  logic        csi_clk;
  logic        rsi_reset_n;
  word_t       avm_m0_address;
  logic        avm_m0_read;
  logic        avm_m0_write;
  word_t       avm_m0_writedata;
  word_t       avm_m0_readdata;
  logic        avm_m0_waitrequest;
  logic        log_valid;
  word_t       log_addr;
  word_t       log_data;

  word_t       prog [$];
  word_t       exp_addr [$];
  word_t       exp_data [$];
  word_t       halt_addr;
  logic        halt_seen;
  logic        preload_valid;
  int          preload_idx;
  word_t       preload_word;
  int          cycle_count;
  int          cycle_limit;
  int          tests;
  int          checks;
  int          errors;

  bexkat_core #(
    .reset_pc (32'h0)
  ) bexkat_core_inst (
    .csi_clk            (csi_clk),
    .rsi_reset_n        (rsi_reset_n),
    .avm_m0_address     (avm_m0_address),
    .avm_m0_read        (avm_m0_read),
    .avm_m0_write       (avm_m0_write),
    .avm_m0_writedata   (avm_m0_writedata),
    .avm_m0_readdata    (avm_m0_readdata),
    .avm_m0_waitrequest (avm_m0_waitrequest)
  );

  tb_bexkat_mem #(
    .wait_max (wait_max)
  ) mem_inst (
    .csi_clk     (csi_clk),
    .address     (avm_m0_address),
    .read        (avm_m0_read),
    .write       (avm_m0_write),
    .writedata   (avm_m0_writedata),
    .readdata    (avm_m0_readdata),
    .waitrequest (avm_m0_waitrequest),
    .log_valid   (log_valid),
    .log_addr    (log_addr),
    .log_data    (log_data)
  );

  initial begin
    csi_clk = 1'b0;
    forever #2 csi_clk = ~csi_clk;
  end

  function automatic word_t sext16(input logic [15:0] x);
    return {{16{x[15]}}, x};
  endfunction

  function automatic word_t sext11(input logic [10:0] x);
    return {{21{x[10]}}, x};
  endfunction

  function automatic word_t enc_reg(input opcode_t op, input reg_addr_t ra,
                                    input reg_addr_t rb, input reg_addr_t rc);
    return {mode_reg, op, ra, rb, rc, 6'd0};
  endfunction

  function automatic word_t enc_imm(input opcode_t op, input reg_addr_t ra,
                                    input logic [15:0] imm);
    return {mode_imm, op, ra, imm};
  endfunction

  function automatic word_t enc_ind(input opcode_t op, input reg_addr_t ra,
                                    input reg_addr_t rb, input logic [10:0] off);
    return {mode_regind, op, ra, rb, off};
  endfunction

  // returns {carry, negative, overflow, zero, result}
  function automatic logic [35:0] ref_alu(input logic [3:0] func, input word_t a,
                                          input word_t b);
    word_t       res;
    logic        c;
    logic        v;
    logic [32:0] wide;
    longint      sa;
    longint      sb;
    longint      s;
    c  = 1'b0;
    v  = 1'b0;
    sa = $signed(a);
    sb = $signed(b);
    case (func)
      4'd0: res = a & b;
      4'd1: res = a | b;
      4'd2: begin
        wide = {1'b0, a} + {1'b0, b};
        res  = wide[31:0];
        c    = wide[32];
        s    = sa + sb;
        v    = (s > 64'sd2147483647) || (s < -64'sd2147483648);
      end
      4'd3: begin
        res = a - b;
        c   = (a < b); // borrow
        s   = sa - sb;
        v   = (s > 64'sd2147483647) || (s < -64'sd2147483648);
      end
      4'd4: res = a ^ b;
      4'd5: res = a << b[4:0];
      4'd6: res = a >> b[4:0];
      4'd7: res = $signed(a) >>> b[4:0];
      default: res = '0;
    endcase
    return {c, res[31], v, (res == '0), res};
  endfunction

  function automatic logic ref_taken(input opcode_t op, input logic [3:0] f);
    logic c;
    logic n;
    logic v;
    logic z;
    {c, n, v, z} = f;
    case (op)
      op_bra:  return 1'b1;
      op_beq:  return z;
      op_bne:  return !z;
      op_bgtu: return !z && !c;
      op_bgt:  return !z && (n == v);
      op_bge:  return n == v;
      op_ble:  return z || (n != v);
      op_blt:  return n != v;
      op_bgeu: return !c;
      op_bltu: return c;
      op_bleu: return c || z;
      default: return 1'b0;
    endcase
  endfunction

  task automatic check_value(input string name, input word_t got, input word_t expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, expected);
    end
  endtask

  task automatic emit(input word_t w);
    prog.push_back(w);
  endtask

  task automatic expect_store(input word_t addr, input word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic store_result(input reg_addr_t ra, input word_t addr, input word_t data);
    emit(enc_ind(op_st_l, ra, 5'd0, addr[10:0]));
    expect_store(addr, data);
  endtask

  always @(posedge csi_clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: the core did not finish its program within %0d cycles", cycle_limit);
      $display("Verification failed");
      $finish;
    end
  end

  always @(negedge csi_clk) begin
    if (rsi_reset_n && avm_m0_read && !avm_m0_waitrequest && avm_m0_address == halt_addr) begin
      halt_seen = 1'b1; // fetch of the closing undefined opcode
    end
  end

  always @(negedge csi_clk) begin
    if (log_valid) begin
      if (exp_addr.size() == 0) begin
        errors++;
        $display("Unexpected store of %h to address %h", log_data, log_addr);
      end else begin
        check_value("avm_m0_address", log_addr, exp_addr.pop_front());
        check_value("avm_m0_writedata", log_data, exp_data.pop_front());
      end
    end
  end

  task automatic run_program(input string name);
    int errors_before;
    int stores;
    errors_before = errors;
    stores        = exp_addr.size();
    emit(enc_reg(8'h01, 5'd0, 5'd0, 5'd0)); // undefined, core faults here
    halt_addr   = word_t'((prog.size() - 1) * 4);
    cycle_limit += prog.size() * max_instr_cyc + reset_cycles + idle_cycles + 10;
    @(posedge csi_clk);
    rsi_reset_n <= 1'b0;
    halt_seen = 1'b0;
    mem_inst.fill_pattern();
    for (int i = 0; i < prog.size(); i++) begin
      mem_inst.load_word(i, prog[i]);
    end
    if (preload_valid) begin
      mem_inst.load_word(preload_idx, preload_word);
    end
    preload_valid = 1'b0;
    repeat (reset_cycles) @(posedge csi_clk);
    rsi_reset_n <= 1'b1;
    wait (halt_seen);
    repeat (2) @(negedge csi_clk);
    repeat (idle_cycles) begin
      @(negedge csi_clk);
      if (avm_m0_read || avm_m0_write) begin
        errors++;
        $display("Bus request seen after the core reached the undefined opcode");
      end
    end
    if (exp_addr.size() != 0) begin
      errors++;
      $display("%0d expected stores never happened", exp_addr.size());
    end
    exp_addr.delete();
    exp_data.delete();
    prog.delete();
    tests++;
    $display("test %0d %s: %0d stores, %s", tests, name, stores,
             (errors == errors_before) ? "ok" : "errors");
  endtask

  task automatic test_alu();
    logic [15:0] a;
    logic [15:0] b;
    logic [35:0] r;
    a = 16'($urandom());
    b = 16'($urandom());
    emit(enc_imm(op_ldis, 5'd1, a));
    emit(enc_imm(op_ldiu, 5'd2, b));
    for (int f = 0; f < 9; f++) begin // code 8 is unused
      r = ref_alu(4'(f), sext16(a), {16'h0, b});
      emit(enc_reg(op_alu_base | opcode_t'(f), 5'd3, 5'd1, 5'd2));
      store_result(5'd3, 32'h200 + 4 * f, r[31:0]);
    end
    run_program("alu functions");
  endtask

  task automatic test_unary();
    logic [15:0] a;
    logic [10:0] off;
    word_t       va;
    a   = 16'($urandom());
    off = 11'($urandom());
    va  = sext16(a);
    emit(enc_imm(op_ldis, 5'd1, a));
    emit(enc_reg(op_mov, 5'd2, 5'd1, 5'd0));
    store_result(5'd2, 32'h240, va);
    emit(enc_reg(op_com, 5'd3, 5'd1, 5'd0));
    store_result(5'd3, 32'h244, ~va);
    emit(enc_reg(op_neg, 5'd4, 5'd1, 5'd0));
    store_result(5'd4, 32'h248, 32'd0 - va);
    emit(enc_reg(op_inc, 5'd2, 5'd0, 5'd0));
    store_result(5'd2, 32'h24c, va + 32'd1);
    emit(enc_reg(op_dec, 5'd3, 5'd0, 5'd0));
    store_result(5'd3, 32'h250, ~va - 32'd1);
    emit(enc_ind(op_lda, 5'd7, 5'd1, off));
    store_result(5'd7, 32'h254, va + sext11(off));
    run_program("unary ops and lda");
  endtask

  task automatic test_branch();
    logic [15:0] x;
    logic [15:0] y;
    logic [35:0] r;
    opcode_t     op;
    word_t       addr;
    emit(enc_imm(op_ldiu, 5'd5, 16'd16)); // shift count for the upper half
    for (int k = 0; k < 12; k++) begin
      op   = op_bra + opcode_t'(k);
      addr = 32'h300 + 4 * k;
      x    = 16'($urandom());
      y    = 16'($urandom());
      if (k % 3 == 0) begin
        y = x; // equal pair
      end else if (k % 3 == 1) begin
        x[15] = 1'b0;
        y     = x ^ 16'h8000; // difference overflows
      end
      r = ref_alu(alu_sub, {x, 16'h0}, {y, 16'h0});
      emit(enc_imm(op_ldis, 5'd1, x));
      emit(enc_imm(op_ldis, 5'd2, y));
      emit(enc_reg(op_alu_base | 8'(alu_shl), 5'd1, 5'd1, 5'd5));
      emit(enc_reg(op_alu_base | 8'(alu_shl), 5'd2, 5'd2, 5'd5));
      emit(enc_reg(op_cmp, 5'd1, 5'd2, 5'd0));
      emit(enc_imm(op, 5'd0, 16'd4)); // skips the marker store
      emit(enc_ind(op_st_l, 5'd1, 5'd0, addr[10:0]));
      if (!ref_taken(op, r[35:32])) begin
        expect_store(addr, {x, 16'h0});
      end
    end
    run_program("cmp and branches");
  endtask

  task automatic test_load();
    word_t       w;
    logic [15:0] c;
    logic [35:0] r;
    w             = $urandom();
    c             = 16'($urandom());
    r             = ref_alu(alu_add, w, sext16(c));
    preload_valid = 1'b1;
    preload_idx   = 32'h380 >> 2;
    preload_word  = w;
    emit(enc_imm(op_ldiu, 5'd1, 16'h0370));
    emit(enc_ind(op_ld_l, 5'd2, 5'd1, 11'h010));
    emit(enc_imm(op_ldis, 5'd3, c));
    emit(enc_reg(op_alu_base | 8'(alu_add), 5'd4, 5'd2, 5'd3));
    emit(enc_ind(op_st_l, 5'd4, 5'd1, 11'h7f0)); // base minus 16
    expect_store(32'h360, r[31:0]);
    run_program("load, add and store");
  endtask

  task automatic test_jump();
    emit(enc_imm(op_ldiu, 5'd1, 16'd24));
    emit(enc_ind(op_jmp, 5'd0, 5'd1, 11'h7f8)); // target is word 4
    emit(enc_imm(op_ldiu, 5'd2, 16'hdead));
    emit(enc_ind(op_st_l, 5'd2, 5'd0, 11'h3c0));
    emit(enc_imm(op_ldiu, 5'd2, 16'h5a5a));
    store_result(5'd2, 32'h3c4, 32'h0000_5a5a);
    run_program("jmp and fault");
  endtask

  initial begin
    rsi_reset_n   = 1'b0;
    halt_addr     = '0;
    halt_seen     = 1'b0;
    preload_valid = 1'b0;
    preload_idx   = 0;
    preload_word  = '0;
    cycle_count   = 0;
    cycle_limit   = 0;
    tests         = 0;
    checks        = 0;
    errors        = 0;
    void'($urandom(32'h1cf6));
    test_alu();
    test_unary();
    test_branch();
    test_load();
    test_jump();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* verification/tb_bexkat_mem.sv */
`timescale 1ns/10ps

module tb_bexkat_mem #(
  parameter int mem_words = 256,
  parameter int wait_max  = 3
) (
  input  logic              csi_clk,
  input  bexkat_pkg::word_t address,
  input  logic              read,
  input  logic              write,
  input  bexkat_pkg::word_t writedata,
  output bexkat_pkg::word_t readdata,
  output logic              waitrequest,
  output logic              log_valid,
  output bexkat_pkg::word_t log_addr,
  output bexkat_pkg::word_t log_data
);

  import bexkat_pkg::*;

  localparam int idx_bits = $clog2(mem_words);

  word_t               mem [mem_words];
  logic [idx_bits-1:0] idx;
  int                  wait_run;

  assign idx = address[idx_bits+1:2];

  initial begin
    readdata    = '0;
    waitrequest = 1'b1; // idle bus waits
    log_valid   = 1'b0;
    log_addr    = '0;
    log_data    = '0;
    wait_run    = 0;
  end

  // each word decodes as an undefined instruction
  task automatic fill_pattern();
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = {3'b111, 29'(i)};
    end
  endtask

  task automatic load_word(input int index, input word_t value);
    mem[index] = value;
  endtask

  always @(posedge csi_clk) begin
    log_valid <= 1'b0;
    if ((read || write) && !waitrequest) begin // access ends at this edge
      if (write) begin
        mem[idx]  <= writedata;
        log_valid <= 1'b1;
        log_addr  <= address;
        log_data  <= writedata;
      end
      waitrequest <= 1'b1;
      wait_run    <= 0;
    end else if (read || write) begin
      readdata <= mem[idx];
      if (wait_run < wait_max && ($urandom() % 3) == 0) begin
        waitrequest <= 1'b1;
        wait_run    <= wait_run + 1;
      end else begin
        waitrequest <= 1'b0;
      end
    end else begin
      waitrequest <= 1'b1;
      wait_run    <= 0;
    end
  end

endmodule

/* logic/bexkat_core.sv */
`timescale 1ns/10ps

module bexkat_core #(
  parameter bexkat_pkg::word_t reset_pc = '0
) (
  input  logic              csi_clk,
  input  logic              rsi_reset_n,
  output bexkat_pkg::word_t avm_m0_address,
  output logic              avm_m0_read,
  output logic              avm_m0_write,
  output bexkat_pkg::word_t avm_m0_writedata,
  input  bexkat_pkg::word_t avm_m0_readdata,
  input  logic              avm_m0_waitrequest
);

  import bexkat_pkg::*;

  reg_addr_t rd_addr1, rd_addr2, wr_addr;
  word_t     rd_data1, rd_data2, wr_data;
  logic      wr_en;
  word_t     alu_in2, alu_result;
  alu_func_t alu_func;
  ccr_t      alu_flags;

  bexkat_control #(
    .reset_pc (reset_pc)
  ) control_inst (
    .csi_clk            (csi_clk),
    .rsi_reset_n        (rsi_reset_n),
    .avm_m0_address     (avm_m0_address),
    .avm_m0_read        (avm_m0_read),
    .avm_m0_write       (avm_m0_write),
    .avm_m0_writedata   (avm_m0_writedata),
    .avm_m0_readdata    (avm_m0_readdata),
    .avm_m0_waitrequest (avm_m0_waitrequest),
    .rd_addr1           (rd_addr1),
    .rd_addr2           (rd_addr2),
    .rd_data1           (rd_data1),
    .rd_data2           (rd_data2),
    .wr_en              (wr_en),
    .wr_addr            (wr_addr),
    .wr_data            (wr_data),
    .alu_in2            (alu_in2),
    .alu_func           (alu_func),
    .alu_result         (alu_result),
    .alu_flags          (alu_flags)
  );

  bexkat_regfile regfile_inst (
    .csi_clk     (csi_clk),
    .rsi_reset_n (rsi_reset_n),
    .rd_addr1    (rd_addr1),
    .rd_addr2    (rd_addr2),
    .rd_data1    (rd_data1),
    .rd_data2    (rd_data2),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data)
  );

  bexkat_alu alu_inst (
    .in1    (rd_data1), // port 1 always feeds the alu
    .in2    (alu_in2),
    .func   (alu_func),
    .result (alu_result),
    .flags  (alu_flags)
  );

endmodule

/* logic/bexkat_control.sv */
`timescale 1ns/10ps

module bexkat_control #(
  parameter bexkat_pkg::word_t reset_pc = '0
) (
  input  logic                  csi_clk,
  input  logic                  rsi_reset_n,
  output bexkat_pkg::word_t     avm_m0_address,
  output logic                  avm_m0_read,
  output logic                  avm_m0_write,
  output bexkat_pkg::word_t     avm_m0_writedata,
  input  bexkat_pkg::word_t     avm_m0_readdata,
  input  logic                  avm_m0_waitrequest,
  output bexkat_pkg::reg_addr_t rd_addr1,
  output bexkat_pkg::reg_addr_t rd_addr2,
  input  bexkat_pkg::word_t     rd_data1,
  input  bexkat_pkg::word_t     rd_data2,
  output logic                  wr_en,
  output bexkat_pkg::reg_addr_t wr_addr,
  output bexkat_pkg::word_t     wr_data,
  output bexkat_pkg::word_t     alu_in2,
  output bexkat_pkg::alu_func_t alu_func,
  input  bexkat_pkg::word_t     alu_result,
  input  bexkat_pkg::ccr_t      alu_flags
);

  import bexkat_pkg::*;

  localparam logic addr_pc  = 1'b0;
  localparam logic addr_mar = 1'b1;

  state_t state, state_next;
  word_t  pc, pc_next;
  word_t  ir, ir_next;
  word_t  mar, mar_next;
  word_t  mdr, mdr_next;
  ccr_t   ccr, ccr_next;
  logic   addrsel, addrsel_next;
  logic   read_next, write_next;

  mode_t     ir_mode;
  opcode_t   ir_op;
  reg_addr_t ir_ra, ir_rb, ir_rc;
  word_t     ir_ind;
  logic      c_flag, n_flag, v_flag, z_flag;
  logic      br_taken;

  assign ir_mode = mode_t'(ir[mode_lsb +: 3]);
  assign ir_op   = ir[op_lsb +: 8];
  assign ir_ra   = ir[ra_lsb +: 5];
  assign ir_rb   = ir[rb_lsb +: 5];
  assign ir_rc   = ir[rc_lsb +: 5];
  assign ir_ind  = {{($bits(word_t) - ind_width){ir[ind_width-1]}}, ir[ind_width-1:0]};

  assign {c_flag, n_flag, v_flag, z_flag} = ccr;

  assign avm_m0_address   = (addrsel == addr_mar) ? mar : pc;
  assign avm_m0_writedata = mdr;

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      state        <= st_fetch;
      pc           <= reset_pc;
      ccr          <= '0;
      addrsel      <= addr_pc;
      avm_m0_read  <= 1'b0;
      avm_m0_write <= 1'b0;
    end else begin
      state        <= state_next;
      pc           <= pc_next;
      ccr          <= ccr_next;
      addrsel      <= addrsel_next;
      avm_m0_read  <= read_next;
      avm_m0_write <= write_next;
    end
  end

  // instruction and memory payload
  always_ff @(posedge csi_clk) begin
    ir  <= ir_next;
    mar <= mar_next;
    mdr <= mdr_next;
  end

  always_comb begin
    case (ir_op)
      op_bra:  br_taken = 1'b1;
      op_beq:  br_taken = z_flag;
      op_bne:  br_taken = !z_flag;
      op_bgtu: br_taken = !(z_flag || c_flag);
      op_bgt:  br_taken = !z_flag && (n_flag == v_flag);
      op_bge:  br_taken = (n_flag == v_flag);
      op_ble:  br_taken = z_flag || (n_flag != v_flag);
      op_blt:  br_taken = (n_flag != v_flag);
      op_bgeu: br_taken = !c_flag;
      op_bltu: br_taken = c_flag;
      op_bleu: br_taken = c_flag || z_flag;
      default: br_taken = 1'b0; // brn and the rest
    endcase
  end

  always_comb begin
    state_next   = state;
    pc_next      = pc;
    ir_next      = ir;
    mar_next     = mar;
    mdr_next     = mdr;
    ccr_next     = ccr;
    addrsel_next = addrsel;
    read_next    = avm_m0_read;
    write_next   = avm_m0_write;
    rd_addr1     = ir_ra;
    rd_addr2     = ir_rb;
    wr_en        = 1'b0;
    wr_addr      = ir_ra;
    wr_data      = alu_result;
    alu_in2      = word_step;
    alu_func     = alu_add;

    case (state)
      st_fetch: begin
        read_next    = 1'b1;
        addrsel_next = addr_pc;
        state_next   = st_memload;
      end
      st_memload: begin
        if (!avm_m0_waitrequest) begin
          read_next = 1'b0;
          if (addrsel == addr_pc) begin // instruction fetch
            ir_next    = avm_m0_readdata;
            mar_next   = {{($bits(word_t) - imm_width){avm_m0_readdata[imm_width-1]}},
                          avm_m0_readdata[imm_width-1:0]};
            mdr_next   = {{($bits(word_t) - imm_width){1'b0}},
                          avm_m0_readdata[imm_width-1:0]};
            pc_next    = pc + word_step;
            state_next = st_eval;
          end else begin
            mdr_next   = avm_m0_readdata;
            state_next = st_load;
          end
        end
      end
      st_memsave: begin
        if (!avm_m0_waitrequest) begin
          write_next = 1'b0;
          state_next = st_store;
        end
      end
      st_eval: begin
        state_next = st_fetch;
        case (ir_mode)
          mode_reg: begin
            if (ir_op[7:4] == op_alu_base[7:4]) begin // rA <= rB op rC
              alu_func = alu_func_t'(ir_op[3:0]);
              rd_addr1 = ir_rb;
              rd_addr2 = ir_rc;
              alu_in2  = rd_data2;
              wr_en    = 1'b1;
            end else begin
              case (ir_op)
                op_nop: ;
                op_cmp: begin
                  alu_func = alu_sub;
                  alu_in2  = rd_data2;
                  ccr_next = alu_flags;
                end
                op_inc: begin
                  alu_in2 = 32'd1;
                  wr_en   = 1'b1;
                end
                op_dec: begin
                  alu_func = alu_sub;
                  alu_in2  = 32'd1;
                  wr_en    = 1'b1;
                end
                op_mov, op_com, op_neg: begin
                  rd_addr1 = ir_rb;
                  wr_en    = 1'b1;
                  if (ir_op == op_mov) begin
                    wr_data = rd_data1;
                  end else if (ir_op == op_com) begin
                    wr_data = ~rd_data1;
                  end else begin
                    wr_data = -rd_data1;
                  end
                end
                default: state_next = st_fault;
              endcase
            end
          end
          mode_imm: begin
            if (ir_op == op_ldis || ir_op == op_ldiu) begin
              wr_en   = 1'b1;
              wr_data = (ir_op == op_ldis) ? mar : mdr;
            end else if (ir_op <= op_brn) begin
              if (br_taken) begin
                pc_next = pc + mar; // pc already stepped
              end
            end else begin
              state_next = st_fault;
            end
          end
          mode_regind: begin
            rd_addr1 = ir_rb;
            rd_addr2 = ir_ra;
            alu_in2  = ir_ind;
            case (ir_op)
              op_st_l: begin
                mar_next     = alu_result;
                mdr_next     = rd_data2;
                addrsel_next = addr_mar;
                write_next   = 1'b1;
                state_next   = st_memsave;
              end
              op_ld_l: begin
                mar_next     = alu_result;
                addrsel_next = addr_mar;
                read_next    = 1'b1;
                state_next   = st_memload;
              end
              op_lda:  wr_en = 1'b1;
              op_jmp:  pc_next = alu_result;
              default: state_next = st_fault;
            endcase
          end
          default: state_next = st_fault;
        endcase
      end
      st_load: begin
        wr_en        = 1'b1;
        wr_data      = mdr;
        addrsel_next = addr_pc;
        state_next   = st_fetch;
      end
      st_store: begin
        addrsel_next = addr_pc;
        state_next   = st_fetch;
      end
      default: state_next = st_fault; // fault holds until reset
    endcase
  end

endmodule

/* logic/bexkat_alu.sv */
`timescale 1ns/10ps

module bexkat_alu (
  input  bexkat_pkg::word_t     in1,
  input  bexkat_pkg::word_t     in2,
  input  bexkat_pkg::alu_func_t func,
  output bexkat_pkg::word_t     result,
  output bexkat_pkg::ccr_t      flags
);

  import bexkat_pkg::*;

  logic [32:0] sum;
  logic [32:0] diff;
  logic [4:0]  shamt;
  logic        carry;
  logic        overflow;

  assign sum   = {1'b0, in1} + {1'b0, in2};
  assign diff  = {1'b0, in1} - {1'b0, in2}; // bit 32 is the borrow
  assign shamt = in2[4:0];

  always_comb begin
    result   = '0;
    carry    = 1'b0;
    overflow = 1'b0;
    case (func)
      alu_and: result = in1 & in2;
      alu_or:  result = in1 | in2;
      alu_add: begin
        result   = sum[31:0];
        carry    = sum[32];
        overflow = (in1[31] == in2[31]) && (sum[31] != in1[31]);
      end
      alu_sub: begin
        result   = diff[31:0];
        carry    = diff[32];
        overflow = (in1[31] != in2[31]) && (diff[31] != in1[31]);
      end
      alu_xor:  result = in1 ^ in2;
      alu_shl:  result = in1 << shamt;
      alu_shr:  result = in1 >> shamt;
      alu_ashr: result = word_t'($signed(in1) >>> shamt);
      default:  result = '0; // unused codes
    endcase
  end

  assign flags = {carry, result[31], overflow, (result == '0)};

endmodule

/* logic/bexkat_regfile.sv */
`timescale 1ns/10ps

module bexkat_regfile (
  input  logic                  csi_clk,
  input  logic                  rsi_reset_n,
  input  bexkat_pkg::reg_addr_t rd_addr1,
  input  bexkat_pkg::reg_addr_t rd_addr2,
  output bexkat_pkg::word_t     rd_data1,
  output bexkat_pkg::word_t     rd_data2,
  input  logic                  wr_en,
  input  bexkat_pkg::reg_addr_t wr_addr,
  input  bexkat_pkg::word_t     wr_data
);

  import bexkat_pkg::*;

  word_t regs [reg_count]; // r31 is sp by convention only

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // async read ports
  assign rd_data1 = regs[rd_addr1];
  assign rd_data2 = regs[rd_addr2];

endmodule

/* logic/bexkat_pkg.sv */
package bexkat_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [7:0]  opcode_t;
  typedef logic [3:0]  ccr_t; // carry, negative, overflow, zero

  typedef enum logic [2:0] {
    mode_reg    = 3'd0,
    mode_regind = 3'd1,
    mode_imm    = 3'd2
  } mode_t;

  typedef enum logic [3:0] {
    alu_and  = 4'd0,
    alu_or   = 4'd1,
    alu_add  = 4'd2,
    alu_sub  = 4'd3,
    alu_xor  = 4'd4,
    alu_shl  = 4'd5,
    alu_shr  = 4'd6,
    alu_ashr = 4'd7
  } alu_func_t;

  typedef enum logic [2:0] {
    st_fetch,
    st_memload,
    st_memsave,
    st_eval,
    st_load,
    st_store,
    st_fault
  } state_t;

  localparam int mode_lsb  = 29;
  localparam int op_lsb    = 21;
  localparam int ra_lsb    = 16;
  localparam int rb_lsb    = 11;
  localparam int rc_lsb    = 6;
  localparam int imm_width = 16;
  localparam int ind_width = 11;

  localparam word_t word_step = 32'd4;
  localparam int    reg_count = 32;

  // register mode
  localparam opcode_t op_nop      = 8'h00;
  localparam opcode_t op_cmp      = 8'h02;
  localparam opcode_t op_inc      = 8'h03;
  localparam opcode_t op_dec      = 8'h04;
  localparam opcode_t op_mov      = 8'h07;
  localparam opcode_t op_com      = 8'h08;
  localparam opcode_t op_neg      = 8'h09;
  localparam opcode_t op_alu_base = 8'h20; // low nibble is the alu func

  // immediate mode
  localparam opcode_t op_bra  = 8'h00;
  localparam opcode_t op_beq  = 8'h01;
  localparam opcode_t op_bne  = 8'h02;
  localparam opcode_t op_bgtu = 8'h03;
  localparam opcode_t op_bgt  = 8'h04;
  localparam opcode_t op_bge  = 8'h05;
  localparam opcode_t op_ble  = 8'h06;
  localparam opcode_t op_blt  = 8'h07;
  localparam opcode_t op_bgeu = 8'h08;
  localparam opcode_t op_bltu = 8'h09;
  localparam opcode_t op_bleu = 8'h0a;
  localparam opcode_t op_brn  = 8'h0b;
  localparam opcode_t op_ldis = 8'h0c;
  localparam opcode_t op_ldiu = 8'h0d;

  // register indirect mode
  localparam opcode_t op_st_l = 8'h00;
  localparam opcode_t op_ld_l = 8'h01;
  localparam opcode_t op_lda  = 8'h0a;
  localparam opcode_t op_jmp  = 8'h0b;

endpackage
